/* adpcm/ADPCMDecoder.sv */
// ADPCM nibble decoder
// One 4-bit nibble plus two history samples to one clamped 16-bit sample, no latency
`timescale 1ns/10ps

module ADPCMDecoder (
	input  adpcmPkg::adpcmHeader_t              i_header,
	input  logic [adpcmPkg::WORD_W-1:0]         i_raw,
	input  logic [1:0]                          i_nibblePos,
	input  adpcmPkg::sampleHist_t               i_hist,
	output logic signed [adpcmPkg::WORD_W-1:0]  o_sample
);

	logic [3:0]         shift;
	logic [2:0]         filter;
	logic signed [7:0]  filterPos;
	logic signed [7:0]  filterNeg;
	logic [3:0]         nibble;
	logic signed [15:0] placed;
	logic signed [15:0] stage1;
	logic signed [15:0] baseSample;
	logic signed [23:0] prod0;
	logic signed [23:0] prod1;
	logic signed [23:0] predSum;
	logic signed [23:0] biased;
	logic signed [17:0] div64;
	logic signed [18:0] sum19;

	// Reserved values, shift 13..15 act as 9
	assign shift  = (i_header.shift < 4'd13) ? i_header.shift : 4'd9;
	assign filter = (i_header.filter < 3'd5) ? i_header.filter : 3'd4;	// 5..7 act as 4

	// Coefficient lookup, filter already in range
	assign filterPos = adpcmPkg::FILTER_POS[filter];
	assign filterNeg = adpcmPkg::FILTER_NEG[filter];

	// Low nibble first
	always_comb begin
		case (i_nibblePos)
			2'd0:    nibble = i_raw[3:0];
			2'd1:    nibble = i_raw[7:4];
			2'd2:    nibble = i_raw[11:8];
			default: nibble = i_raw[15:12];
		endcase
	end

	// Nibble sits at the top, sign comes along for free
	assign placed = {nibble, 12'd0};

	// Two-stage arithmetic shifter
	// Fine step 0..3 first, then coarse step of 0/4/8/12
	always_comb begin
		stage1     = placed >>> shift[1:0];
		baseSample = stage1 >>> {shift[3:2], 2'b00};
	end

	// Predictor products, 16x8 fits in 24 bits
	assign prod0 = $signed(i_hist.prev0) * filterPos;
	assign prod1 = $signed(i_hist.prev1) * filterNeg;

	// Worst case sum stays well inside 24 bits
	assign predSum = prod0 + prod1 + 24'sd32;

	// Truncate toward zero
	// Negative values get a bias of 63 before the shift
	assign biased = predSum + (predSum[23] ? 24'sd63 : 24'sd0);
	assign div64  = biased[23:6];

	// 19-bit add leaves room for overflow
	assign sum19 = {div64[17], div64} + {{3{baseSample[15]}}, baseSample};

	// Saturate to signed 16 bits
	always_comb begin
		if (sum19[18:15] == 4'b0000 || sum19[18:15] == 4'b1111) begin
			o_sample = sum19[15:0];		// In range
		end else if (sum19[18]) begin
			o_sample = 16'sh8000;		// Below -32768
		end else begin
			o_sample = 16'sh7FFF;		// Above 32767
		end
	end

endmodule

/* adpcm/adpcmBlockSequencer.sv */
// ADPCM block sequencer
// Walks blocks, words and nibbles, holds header and history, runs the sample handshake
`timescale 1ns/10ps

module adpcmBlockSequencer (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic                                i_start,
	input  logic [adpcmPkg::ADDR_W-1:0]         i_startAddr,
	input  logic [adpcmPkg::COUNT_W-1:0]        i_blockCount,
	output logic                                o_busy,
	output logic                                o_load,
	output logic [adpcmPkg::ADDR_W-1:0]         o_loadAddr,
	output logic                                o_fetch,
	input  logic                                i_wordValid,
	input  logic [adpcmPkg::WORD_W-1:0]         i_word,
	output adpcmPkg::adpcmHeader_t              o_header,
	output logic [adpcmPkg::WORD_W-1:0]         o_dataWord,
	output logic [1:0]                          o_nibblePos,
	output adpcmPkg::sampleHist_t               o_hist,
	input  logic signed [adpcmPkg::WORD_W-1:0]  i_decoded,
	output logic                                o_sampleReq,
	output logic signed [adpcmPkg::WORD_W-1:0]  o_sample,
	input  logic                                i_sampleAck
);

	localparam int WIDX_W = $clog2(adpcmPkg::WORDS_PER_BLOCK);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,	// One-cycle fetch pulse
		S_WAIT,		// Wait for word valid
		S_OFFER,	// Decoder inputs settle, latch sample
		S_ACK_HI,
		S_ACK_LO
	} seqState_t;

	seqState_t                    state;
	logic [WIDX_W-1:0]            wordIdx;		// 0 is the header
	logic [adpcmPkg::COUNT_W-1:0] blocksLeft;
	logic                         fetchPending;
	logic                         accept;

	// Zero block count is a no-op
	assign accept     = (state == S_IDLE) && i_start && (i_blockCount != '0);
	assign o_load     = accept;		// Address base goes to fetch unit
	assign o_loadAddr = i_startAddr;
	assign o_fetch    = (state == S_FETCH);
	assign o_busy     = (state != S_IDLE);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state       <= S_IDLE;
			wordIdx     <= '0;
			blocksLeft  <= '0;
			o_nibblePos <= 2'd0;
			o_sampleReq <= 1'b0;
			o_hist      <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						blocksLeft <= i_blockCount;
						wordIdx    <= '0;
						o_hist     <= '0;	// Fresh history per run
						state      <= S_FETCH;
					end
				end
				S_FETCH: state <= S_WAIT;
				S_WAIT: begin
					if (i_wordValid) begin
						if (wordIdx == '0) begin
							wordIdx <= wordIdx + 1'b1;	// Header done, first data word next
							state   <= S_FETCH;
						end else begin
							o_nibblePos <= 2'd0;
							state       <= S_OFFER;
						end
					end
				end
				S_OFFER: begin
					o_sampleReq <= 1'b1;
					state       <= S_ACK_HI;
				end
				S_ACK_HI: begin
					if (i_sampleAck) begin
						o_sampleReq  <= 1'b0;
						o_hist.prev1 <= o_hist.prev0;	// Shift history on accept
						o_hist.prev0 <= o_sample;
						state        <= S_ACK_LO;
					end
				end
				S_ACK_LO: begin
					if (!i_sampleAck) begin
						if (o_nibblePos != 2'(adpcmPkg::NIBBLES_PER_WORD - 1)) begin
							o_nibblePos <= o_nibblePos + 2'd1;
							state       <= S_OFFER;
						end else if (wordIdx != WIDX_W'(adpcmPkg::WORDS_PER_BLOCK - 1)) begin
							wordIdx <= wordIdx + 1'b1;
							state   <= S_FETCH;
						end else if (blocksLeft == 1) begin
							state <= S_IDLE;	// Last sample of the run
						end else begin
							blocksLeft <= blocksLeft - 1'b1;
							wordIdx    <= '0;	// Next header, history carries over
							state      <= S_FETCH;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Header and data word capture
	always_ff @(posedge i_clk) begin
		if (state == S_WAIT && i_wordValid) begin
			if (wordIdx == '0) o_header <= i_word;
			else o_dataWord <= i_word;
		end
	end

	// Sample only changes while the port is quiet
	always_ff @(posedge i_clk) begin
		if (state == S_OFFER) o_sample <= i_decoded;
	end

	// Tracks a fetch still in flight
	always_ff @(posedge i_clk) begin
		if (i_rst) fetchPending <= 1'b0;
		else if (o_fetch) fetchPending <= 1'b1;
		else if (i_wordValid) fetchPending <= 1'b0;
	end

	assert property (@(posedge i_clk) disable iff (i_rst)
		o_sampleReq |=> $stable(o_sample))
		else $error("o_sample changed during sample request");

	assert property (@(posedge i_clk) disable iff (i_rst)
		o_fetch |-> !fetchPending)
		else $error("fetch issued while previous fetch outstanding");

endmodule

/* adpcmStream.f */
common/adpcmPkg.sv
adpcm/ADPCMDecoder.sv
adpcm/adpcmBlockSequencer.sv
hdl/adpcmWordFetch.sv
hdl/adpcmStreamTop.sv
test/tb_adpcmStream.sv

/* common/adpcmPkg.sv */
// ADPCM stream package
// Block geometry, bus widths, predictor coefficients and shared structs

package adpcmPkg;

	// Bus widths
	localparam int WORD_W  = 16;	// Memory word and sample
	localparam int ADDR_W  = 16;	// Word address
	localparam int COUNT_W = 8;		// Block count

	// Block geometry, header word plus seven data words
	localparam int WORDS_PER_BLOCK  = 8;
	localparam int NIBBLES_PER_WORD = 4;

	// Fixed predictor filters, indexed by clamped filter 0..4
	localparam logic signed [7:0] FILTER_POS [0:4] = '{
		8'sd0, 8'sd60, 8'sd115, 8'sd98, 8'sd122
	};
	localparam logic signed [7:0] FILTER_NEG [0:4] = '{
		8'sd0, 8'sd0, -8'sd52, -8'sd55, -8'sd60
	};

	// Block header word
	typedef struct packed {
		logic [8:0] unused;		// Bits 15:7, ignored
		logic [2:0] filter;		// Bits 6:4
		logic [3:0] shift;		// Bits 3:0
	} adpcmHeader_t;

	// Two-sample decoder history
	typedef struct packed {
		logic signed [WORD_W-1:0] prev0;	// Newest
		logic signed [WORD_W-1:0] prev1;	// Older
	} sampleHist_t;

endpackage

/* hdl/adpcmStreamTop.sv */
// ADPCM stream top
// Memory fetch, block sequencer and nibble decoder for one voice
`timescale 1ns/10ps

module adpcmStreamTop (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic                                i_start,
	input  logic [adpcmPkg::ADDR_W-1:0]         i_startAddr,
	input  logic [adpcmPkg::COUNT_W-1:0]        i_blockCount,
	output logic                                o_busy,
	output logic                                o_memReq,
	output logic [adpcmPkg::ADDR_W-1:0]         o_memAddr,
	input  logic                                i_memAck,
	input  logic [adpcmPkg::WORD_W-1:0]         i_memData,
	output logic                                o_sampleReq,
	output logic signed [adpcmPkg::WORD_W-1:0]  o_sample,
	input  logic                                i_sampleAck
);

	logic                                load;
	logic [adpcmPkg::ADDR_W-1:0]         loadAddr;
	logic                                fetch;
	logic                                wordValid;
	logic [adpcmPkg::WORD_W-1:0]         word;
	adpcmPkg::adpcmHeader_t              header;
	logic [adpcmPkg::WORD_W-1:0]         dataWord;
	logic [1:0]                          nibblePos;
	adpcmPkg::sampleHist_t               hist;
	logic signed [adpcmPkg::WORD_W-1:0]  decoded;

	// Memory side
	adpcmWordFetch u_fetch (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_load(load), .i_loadAddr(loadAddr),
		.i_fetch(fetch), .o_wordValid(wordValid), .o_word(word),
		.o_memReq(o_memReq), .o_memAddr(o_memAddr),
		.i_memAck(i_memAck), .i_memData(i_memData)
	);

	// Control and sample side
	adpcmBlockSequencer u_seq (
		.i_clk(i_clk), .i_rst(i_rst), .i_start(i_start),
		.i_startAddr(i_startAddr), .i_blockCount(i_blockCount), .o_busy(o_busy),
		.o_load(load), .o_loadAddr(loadAddr),
		.o_fetch(fetch), .i_wordValid(wordValid), .i_word(word),
		.o_header(header), .o_dataWord(dataWord), .o_nibblePos(nibblePos),
		.o_hist(hist), .i_decoded(decoded),
		.o_sampleReq(o_sampleReq), .o_sample(o_sample), .i_sampleAck(i_sampleAck)
	);

	// Zero-latency nibble decode
	ADPCMDecoder u_dec (
		.i_header(header), .i_raw(dataWord), .i_nibblePos(nibblePos),
		.i_hist(hist), .o_sample(decoded)
	);

endmodule

/* hdl/adpcmWordFetch.sv */
// ADPCM word fetch
// Four-phase req/ack master on the memory port, one word per fetch pulse
`timescale 1ns/10ps

module adpcmWordFetch (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_load,
	input  logic [adpcmPkg::ADDR_W-1:0]  i_loadAddr,
	input  logic                         i_fetch,
	output logic                         o_wordValid,
	output logic [adpcmPkg::WORD_W-1:0]  o_word,
	output logic                         o_memReq,
	output logic [adpcmPkg::ADDR_W-1:0]  o_memAddr,
	input  logic                         i_memAck,
	input  logic [adpcmPkg::WORD_W-1:0]  i_memData
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_ACK_HI,	// Req up, waiting for ack
		F_DELIVER,	// Word valid pulse
		F_ACK_LO	// Req down, waiting for ack release
	} fetchState_t;

	fetchState_t state;
	logic        pending;	// Fetch arrived during release phase

	assign o_wordValid = (state == F_DELIVER);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state    <= F_IDLE;
			pending  <= 1'b0;
			o_memReq <= 1'b0;
		end else begin
			case (state)
				F_IDLE: begin
					if (i_fetch || pending) begin
						o_memReq <= 1'b1;
						pending  <= 1'b0;
						state    <= F_ACK_HI;
					end
				end
				F_ACK_HI: begin
					pending <= pending | i_fetch;
					if (i_memAck) begin
						o_memReq <= 1'b0;	// Data latched this edge
						state    <= F_DELIVER;
					end
				end
				F_DELIVER: begin
					pending <= pending | i_fetch;	// Decoding overlaps release
					state   <= F_ACK_LO;
				end
				default: begin
					pending <= pending | i_fetch;
					if (!i_memAck) state <= F_IDLE;	// Handshake complete
				end
			endcase
		end
	end

	// Word capture
	always_ff @(posedge i_clk) begin
		if (state == F_ACK_HI && i_memAck) o_word <= i_memData;
	end

	// Address counter, steps after each completed transfer
	always_ff @(posedge i_clk) begin
		if (i_rst) o_memAddr <= '0;
		else if (i_load) o_memAddr <= i_loadAddr;
		else if (state == F_ACK_LO && !i_memAck) o_memAddr <= o_memAddr + 1'b1;
	end

	assert property (@(posedge i_clk) disable iff (i_rst)
		o_memReq |=> $stable(o_memAddr))
		else $error("o_memAddr changed during memory request");

	assert property (@(posedge i_clk) disable iff (i_rst)
		(!o_memReq && i_memAck) |=> !o_memReq)
		else $error("o_memReq raised while i_memAck still high");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ADPCM stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_adpcmStream -f adpcmStream.f -o Vtb_adpcmStream \
	&& ./obj_dir/Vtb_adpcmStream > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } \
	|| grep -q "Test OK" sim.log \
	|| { echo "Simulation ended without a result"; exit 1; }

exit 0

/* test/adpcm_stim.txt */
# S start_addr block_count
# M eight memory words of one block, header first
# E four expected samples in output order
S 0040 03
# block 1: shift 12, filter 0
M 000C 3210 7654 BA98 FEDC 1F2E 8070 4C5D
# block 2: shift 13 (acts as 9), filter 1
M 001D 0007 0000 0009 0000 0000 0000 0003
# block 3: shift 0, filter 6 (acts as 4)
M 0060 8777 8888 8888 8888 8888 8888 7777
# block 1 samples
E 0000 0001 0002 0003
E 0004 0005 0006 0007
E FFF8 FFF9 FFFA FFFB
E FFFC FFFD FFFE FFFF
E FFFE 0002 FFFF 0001
E 0000 0007 0000 FFF8
E FFFD 0005 FFFC 0004
# block 2 samples
E 003C 0038 0035 0032
E 002F 002C 0029 0026
E FFEC FFEE FFF0 FFF2
E FFF4 FFF6 FFF8 FFF9
E FFFA FFFB FFFC FFFD
E FFFE FFFF 0000 0000
E 0018 0017 0016 0015
# block 3 samples
E 7013 7FFF 7FFF FBFF
E 8000 8000 8000 8000
E 8000 8000 8000 8000
E 8000 8000 8000 8000
E 8000 8000 8000 8000
E 8000 8000 8000 8000
E F401 7FFF 7FFF 7FFF

/* test/tb_adpcmStream.sv */
// ADPCM stream testbench
// Plays the word memory and the sample sink, checks samples against the stim file
`timescale 1ns/10ps

module tb_adpcmStream;

	logic        i_clk = 1'b0;
	logic        i_rst;
	logic        i_start;
	logic [15:0] i_startAddr;
	logic [7:0]  i_blockCount;
	logic        o_busy;
	logic        o_memReq;
	logic [15:0] o_memAddr;
	logic        i_memAck;
	logic [15:0] i_memData;
	logic        o_sampleReq;
	logic [15:0] o_sample;
	logic        i_sampleAck;

	logic [15:0] mem [0:65535];
	logic [15:0] expSamples [0:1023];
	int          nExp = 0;
	logic [15:0] stimAddr;
	logic [7:0]  stimCount;
	integer      seed = 32'he0440bc4;
	int          cycles = 0;
	int          cycleLimit = 1000;
	int          testErr [0:5];	// Reset, blk1, blk2, blk3, traffic, restart
	int          runNum = 0;
	int          sampleNo = 0;
	int          fetchCount = 0;
	logic [15:0] expAddr;
	logic        portSeen = 1'b0;
	logic [15:0] heldSample;

	adpcmStreamTop u_dut (
		.i_clk(i_clk), .i_rst(i_rst), .i_start(i_start),
		.i_startAddr(i_startAddr), .i_blockCount(i_blockCount), .o_busy(o_busy),
		.o_memReq(o_memReq), .o_memAddr(o_memAddr),
		.i_memAck(i_memAck), .i_memData(i_memData),
		.o_sampleReq(o_sampleReq), .o_sample(o_sample), .i_sampleAck(i_sampleAck)
	);

	always #5 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout after %0d cycles, DUT stopped making progress", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// Tagged lines: S addr count, M eight words, E four samples
	task automatic readStim(output bit ok);
		int          fd;
		int          n;
		int          memCount;
		string       line;
		string       tag;
		logic [15:0] w [0:7];
		ok = 1'b1;
		memCount = 0;
		fd = $fopen("test/adpcm_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open test/adpcm_stim.txt");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n == 0) break;
				if (line.len() < 2 || line.getc(0) == "#") continue;
				n = $sscanf(line, "%s", tag);
				if (tag == "S") begin
					n = $sscanf(line, "%s %h %h", tag, stimAddr, stimCount);
				end else if (tag == "M") begin
					n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag,
						w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
					for (int i = 0; i < 8; i++) begin
						mem[stimAddr + 16'(memCount)] = w[i];
						memCount++;
					end
				end else if (tag == "E") begin
					n = $sscanf(line, "%s %h %h %h %h", tag, w[0], w[1], w[2], w[3]);
					for (int i = 0; i < 4; i++) begin
						expSamples[nExp] = w[i];
						nExp++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One start pulse, then wait for busy to drop
	task automatic runBlocks(input logic [7:0] count, input int expCount, input int errIdx);
		@(negedge i_clk);
		runNum++;
		sampleNo = 0;
		fetchCount = 0;
		expAddr = stimAddr;
		i_start = 1'b1;
		i_startAddr = stimAddr;
		i_blockCount = count;
		@(negedge i_clk);
		i_start = 1'b0;
		if (!o_busy) begin
			$display("o_busy did not rise after start");
			testErr[errIdx]++;
		end
		while (o_busy) begin
			@(negedge i_clk);
			if (!o_busy && (i_sampleAck || sampleNo != expCount)) begin
				$display("o_busy fell before the last sample ack dropped");
				testErr[errIdx]++;
			end
		end
		if (sampleNo != expCount) begin
			$display("CHECK FAILED at %0t: sample count expected %0d got %0d",
				$time, expCount, sampleNo);
			testErr[errIdx]++;
		end
		if (fetchCount != 8 * count) begin
			$display("CHECK FAILED at %0t: fetch count expected %0d got %0d",
				$time, 8 * count, fetchCount);
			testErr[4]++;
		end
	endtask

	// Memory model, random answer delay
	initial begin : memModel
		int delay;
		i_memAck = 1'b0;
		i_memData = '0;
		forever begin
			@(negedge i_clk);
			if (o_memReq && !i_memAck) begin
				delay = unsigned'($random(seed)) % 4;
				repeat (delay) @(negedge i_clk);
				if (o_memAddr !== expAddr) begin
					$display("CHECK FAILED at %0t: o_memAddr expected %h got %h",
						$time, expAddr, o_memAddr);
					testErr[4]++;
				end
				expAddr = expAddr + 16'd1;	// Strictly sequential words
				fetchCount++;
				i_memData = mem[o_memAddr];
				i_memAck = 1'b1;
				while (o_memReq) @(negedge i_clk);
				i_memAck = 1'b0;
			end
		end
	end

	// Sample sink, random ack delay
	initial begin : sampleSink
		int delay;
		int bin;
		i_sampleAck = 1'b0;
		forever begin
			@(negedge i_clk);
			if (o_sampleReq && !i_sampleAck) begin
				delay = unsigned'($random(seed)) % 6;
				repeat (delay) @(negedge i_clk);
				bin = (runNum == 1) ? 1 + sampleNo / 28 : 5;
				if (bin > 3) bin = (runNum == 1) ? 3 : 5;
				if (sampleNo >= nExp || o_sample !== expSamples[sampleNo]) begin
					$display("CHECK FAILED at %0t: o_sample[%0d] expected %h got %h",
						$time, sampleNo, expSamples[sampleNo], o_sample);
					testErr[bin]++;
				end
				sampleNo++;
				i_sampleAck = 1'b1;
				while (o_sampleReq) @(negedge i_clk);
				i_sampleAck = 1'b0;
			end
		end
	end

	// Sample must hold while req or ack is up
	always @(negedge i_clk) begin
		if ((o_sampleReq || i_sampleAck) && portSeen && o_sample !== heldSample) begin
			$display("CHECK FAILED at %0t: o_sample expected %h got %h",
				$time, heldSample, o_sample);
			testErr[4]++;
		end
		portSeen <= o_sampleReq || i_sampleAck;
		heldSample <= o_sample;
	end

	initial begin : mainSeq
		int failed;
		int total;
		bit stimOk;
		i_rst = 1'b1;
		i_start = 1'b0;
		i_startAddr = '0;
		i_blockCount = '0;
		for (int i = 0; i < 6; i++) testErr[i] = 0;
		for (int a = 0; a < 65536; a++) mem[a] = 16'(a) ^ 16'hA5A5;	// Background fill
		readStim(stimOk);
		if (!stimOk) begin
			$display("Test FAILED");
			$finish;
		end else begin
			cycleLimit = 40 * (nExp + 28) + 200;

			// Reset held for 4 cycles, outputs quiet throughout
			repeat (4) begin
				@(negedge i_clk);
				if (o_busy || o_memReq || o_sampleReq) begin
					$display("Outputs active during reset");
					testErr[0]++;
				end
			end
			i_rst = 1'b0;
			@(negedge i_clk);
			if (o_busy || o_memReq || o_sampleReq) begin
				$display("Outputs active just after reset");
				testErr[0]++;
			end
			$display("reset outputs      : %s", testErr[0] == 0 ? "pass" : "fail");

			runBlocks(stimCount, nExp, 3);
			$display("block 1 nibbles    : %s", testErr[1] == 0 ? "pass" : "fail");
			$display("block 2 history    : %s", testErr[2] == 0 ? "pass" : "fail");
			$display("block 3 saturation : %s", testErr[3] == 0 ? "pass" : "fail");

			runBlocks(8'd1, 28, 5);	// Block 1 again, history cleared
			$display("memory traffic     : %s", testErr[4] == 0 ? "pass" : "fail");
			$display("restart            : %s", testErr[5] == 0 ? "pass" : "fail");

			failed = 0;
			total = 0;
			for (int i = 0; i < 6; i++) begin
				if (testErr[i] != 0) failed++;
				total += testErr[i];
			end
			$display("tests run 6, passed %0d, failed %0d, check errors %0d",
				6 - failed, failed, total);
			if (failed == 0) begin
				$display("Test OK");
			end else begin
				$display("Test FAILED");
			end
			$finish;
		end
	end

endmodule
